// File: flist.f
hw/uart_pkg.sv
hw/uart_rx_frame_if.sv
hw/uart_bit_timer.sv
hw/uart_receiver.sv
hw/uart_frame_checker.sv
hw/uart_transmitter.sv
hw/uart_comm.sv
verification/uart_comm_tb.sv

// File: hw/uart_bit_timer.sv
`timescale 1ns/1ps

module uart_bit_timer import uart_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic restart,
  output logic mid_tick,
  output logic end_tick
);

  logic [tick_cnt_w-1:0] count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (restart || end_tick) begin
      count <= '0;  // Restart wins so the owner can realign to a new bit edge
    end else begin
      count <= count + 1'b1;
    end
  end

  // Count is zero in the first cycle after restart
  assign mid_tick = (count == tick_cnt_w'(half_bit - 1));
  assign end_tick = (count == tick_cnt_w'(clks_per_bit - 1));

endmodule

// File: hw/uart_comm.sv
`timescale 1ns/1ps

module uart_comm import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  input  logic       recv_en,
  output uart_byte_t recv_data,
  output logic       recv_valid,
  output uart_err_t  recv_error,
  input  logic       send_en,
  input  uart_byte_t send_data,
  output logic       send_done,
  output logic       tx
);

  uart_rx_frame_if frame_if ();  // Raw frame from receiver to checker

  uart_receiver u_receiver (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .recv_en (recv_en),
    .frame   (frame_if.receiver)
  );

  uart_frame_checker u_frame_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .frame      (frame_if.frame_check),
    .recv_data  (recv_data),
    .recv_valid (recv_valid),
    .recv_error (recv_error)
  );

  uart_transmitter u_transmitter (
    .clk       (clk),
    .rst_n     (rst_n),
    .send_en   (send_en),
    .send_data (send_data),
    .tx        (tx),
    .send_done (send_done)
  );

endmodule

// File: hw/uart_frame_checker.sv
`timescale 1ns/1ps

module uart_frame_checker import uart_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  uart_rx_frame_if.frame_check frame,
  output uart_byte_t           recv_data,
  output logic                 recv_valid,
  output uart_err_t            recv_error
);

  logic parity_err;
  logic frame_err;

  // Even parity means data and parity bit together hold an even number of ones
  assign parity_err = ^{frame.data, frame.parity_bit};
  assign frame_err  = ~frame.stop_bit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      recv_valid <= 1'b0;
      recv_data  <= '0;
      recv_error <= '0;
    end else begin
      recv_valid <= frame.frame_valid;
      if (frame.frame_valid) begin
        recv_data              <= frame.data;  // Published even with errors
        recv_error[err_parity] <= parity_err;
        recv_error[err_frame]  <= frame_err;
      end
    end
  end

endmodule

// File: hw/uart_pkg.sv
package uart_pkg;

  localparam int clks_per_bit = 10;  // One serial bit lasts this many clocks
  localparam int half_bit     = clks_per_bit / 2;
  localparam int tick_cnt_w   = $clog2(clks_per_bit);
  localparam int data_bits    = 8;

  localparam int err_parity   = 0;  // Index of the parity error flag
  localparam int err_frame    = 1;  // Index of the stop-bit error flag

  typedef logic [3:0]           bit_count_t;
  typedef logic [data_bits-1:0] uart_byte_t;
  typedef logic [1:0]           uart_err_t;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_t;

  typedef enum logic [2:0] {
    tx_idle,
    tx_start,
    tx_data,
    tx_parity,
    tx_stop
  } tx_state_t;

endpackage

// File: hw/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver import uart_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rx,
  input  logic              recv_en,
  uart_rx_frame_if.receiver frame
);

  rx_state_t  state;
  bit_count_t bit_cnt;
  uart_byte_t shift_reg;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_sync_d;
  logic       start_edge;
  logic       timer_restart;
  logic       mid_tick;

  uart_bit_timer u_bit_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (timer_restart),
    .mid_tick (mid_tick),
    .end_tick ()
  );

  // Line idles high, so the flops come out of reset high as well
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta   <= 1'b1;
      rx_sync   <= 1'b1;
      rx_sync_d <= 1'b1;
    end else begin
      rx_meta   <= rx;
      rx_sync   <= rx_meta;
      rx_sync_d <= rx_sync;
    end
  end

  assign start_edge    = rx_sync_d & ~rx_sync;
  assign timer_restart = (state == rx_idle) && recv_en && start_edge;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state             <= rx_idle;
      bit_cnt           <= '0;
      frame.frame_valid <= 1'b0;
    end else begin
      frame.frame_valid <= 1'b0;
      case (state)
        rx_idle: begin
          if (timer_restart) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (mid_tick) begin
            bit_cnt <= '0;
            if (rx_sync) begin
              state <= rx_idle;  // Glitch on the line, not a real start bit
            end else begin
              state <= rx_data;
            end
          end
        end
        rx_data: begin
          if (mid_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == bit_count_t'(data_bits - 1)) begin
              state <= rx_parity;
            end
          end
        end
        rx_parity: begin
          if (mid_tick) begin
            state <= rx_stop;
          end
        end
        rx_stop: begin
          if (mid_tick) begin
            frame.frame_valid <= 1'b1;
            state             <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (mid_tick) begin
      case (state)
        rx_data:   shift_reg <= {rx_sync, shift_reg[data_bits-1:1]};  // LSB arrives first
        rx_parity: frame.parity_bit <= rx_sync;
        rx_stop:   frame.stop_bit <= rx_sync;
        default:   ;
      endcase
    end
  end

  assign frame.data = shift_reg;

endmodule

// File: hw/uart_rx_frame_if.sv
`timescale 1ns/1ps

interface uart_rx_frame_if import uart_pkg::*; ();

  logic       frame_valid;  // One-cycle strobe that marks the payload valid
  uart_byte_t data;
  logic       parity_bit;
  logic       stop_bit;

  modport receiver (
    output frame_valid,
    output data,
    output parity_bit,
    output stop_bit
  );

  modport frame_check (
    input frame_valid,
    input data,
    input parity_bit,
    input stop_bit
  );

endinterface

// File: hw/uart_transmitter.sv
`timescale 1ns/1ps

module uart_transmitter import uart_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       send_en,
  input  uart_byte_t send_data,
  output logic       tx,
  output logic       send_done
);

  tx_state_t  state;
  bit_count_t bit_cnt;
  uart_byte_t shift_reg;
  logic       parity;
  logic       load;
  logic       last_bit;
  logic       shift_out;
  logic       end_tick;

  uart_bit_timer u_bit_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (load),
    .mid_tick (),
    .end_tick (end_tick)
  );

  assign send_done = (state == tx_stop) && end_tick;  // Last cycle of the stop bit
  // A new frame may follow the stop bit without an idle gap
  assign load      = send_en && ((state == tx_idle) || send_done);
  assign last_bit  = (bit_cnt == bit_count_t'(data_bits - 1));
  assign shift_out = end_tick && ((state == tx_start) || ((state == tx_data) && !last_bit));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= tx_idle;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end else begin
      case (state)
        tx_idle: begin
          tx <= 1'b1;
          if (load) begin
            state <= tx_start;
            tx    <= 1'b0;
          end
        end
        tx_start: begin
          if (end_tick) begin
            state   <= tx_data;
            bit_cnt <= '0;
            tx      <= shift_reg[0];
          end
        end
        tx_data: begin
          if (end_tick) begin
            if (last_bit) begin
              state <= tx_parity;
              tx    <= parity;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              tx      <= shift_reg[0];
            end
          end
        end
        tx_parity: begin
          if (end_tick) begin
            state <= tx_stop;
            tx    <= 1'b1;
          end
        end
        tx_stop: begin
          if (load) begin
            state <= tx_start;
            tx    <= 1'b0;
          end else if (end_tick) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  // Parity accumulates each bit as it leaves the shift register
  always_ff @(posedge clk) begin
    if (load) begin
      shift_reg <= send_data;
      parity    <= 1'b0;
    end else if (shift_out) begin
      shift_reg <= shift_reg >> 1;
      parity    <= parity ^ shift_reg[0];
    end
  end

endmodule

// File: verification/uart_comm_tb.sv
`timescale 1ns/1ps

module uart_comm_tb import uart_pkg::*; ();

  localparam int   num_tests      = 10;
  localparam int   frame_bits     = 11;
  localparam int   frame_cycles   = frame_bits * clks_per_bit;
  localparam int   timeout_cycles = num_tests * frame_bits * clks_per_bit * 2 + 200;
  localparam logic kind_rx        = 1'b0;
  localparam logic kind_tx        = 1'b1;

  typedef struct packed {
    logic       kind;
    uart_byte_t data;
    logic       corrupt_parity;
    logic       corrupt_stop;
    logic       recv_en;
    logic       keep_send;  // Hold send_en so the next tx entry follows back to back
    uart_err_t  exp_err;
  } stim_t;

  logic       clk;
  logic       rst_n;
  logic       rx;
  logic       recv_en;
  uart_byte_t recv_data;
  logic       recv_valid;
  uart_err_t  recv_error;
  logic       send_en;
  uart_byte_t send_data;
  logic       send_done;
  logic       tx;

  stim_t      stim [num_tests];
  integer     seed;
  int         error_count;
  int         pass_count;
  int         fail_count;
  int         cycle_count;
  uart_byte_t last_rx_byte;

  uart_comm UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .recv_en    (recv_en),
    .recv_data  (recv_data),
    .recv_valid (recv_valid),
    .recv_error (recv_error),
    .send_en    (send_en),
    .send_data  (send_data),
    .send_done  (send_done),
    .tx         (tx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic even_parity(input uart_byte_t data);
    return ^data;  // Parity bit that makes the count of ones even
  endfunction

  task automatic check_byte(input uart_byte_t got, input uart_byte_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
    end
  endtask

  task automatic check_error(input uart_err_t got, input uart_err_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s got %02b expected %02b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic set_entry(input int idx, input logic kind, input logic corrupt_parity,
                           input logic corrupt_stop, input logic en, input logic keep);
    integer rnd;
    rnd = $random(seed);
    stim[idx].kind                = kind;
    stim[idx].data                = rnd[7:0];
    stim[idx].corrupt_parity      = corrupt_parity;
    stim[idx].corrupt_stop        = corrupt_stop;
    stim[idx].recv_en             = en;
    stim[idx].keep_send           = keep;
    stim[idx].exp_err             = '0;
    stim[idx].exp_err[err_parity] = corrupt_parity;
    stim[idx].exp_err[err_frame]  = corrupt_stop;
  endtask

  // Frame goes out LSB first as start, 8 data bits, parity and stop
  task automatic drive_rx_frame(input uart_byte_t data, input logic corrupt_parity,
                                input logic corrupt_stop);
    logic [frame_bits-1:0] bits;
    int                    k;
    bits = {~corrupt_stop, even_parity(data) ^ corrupt_parity, data, 1'b0};
    @(posedge clk);
    for (k = 0; k < frame_bits; k++) begin
      rx <= bits[k];
      repeat (clks_per_bit) @(posedge clk);
    end
    rx <= 1'b1;
    if (corrupt_stop) begin
      repeat (clks_per_bit) @(posedge clk);  // Line has to look idle again before the next frame
    end
  endtask

  task automatic count_recv_valid(input int window, output int pulses,
                                  output uart_byte_t data, output uart_err_t err);
    pulses = 0;
    data   = '0;
    err    = '0;
    repeat (window) begin
      @(negedge clk);
      if (recv_valid === 1'b1) begin
        pulses = pulses + 1;
        data   = recv_data;
        err    = recv_error;
      end
    end
  endtask

  task automatic run_rx_entry(input stim_t e);
    int         pulses;
    uart_byte_t got_data;
    uart_err_t  got_err;
    @(posedge clk);
    recv_en <= e.recv_en;
    @(negedge clk);
    fork
      drive_rx_frame(e.data, e.corrupt_parity, e.corrupt_stop);
      count_recv_valid(12 * clks_per_bit, pulses, got_data, got_err);
    join
    if (e.recv_en) begin
      if (pulses == 0) begin
        error_count++;
        $display("No recv_valid pulse came for byte 0x%02h", e.data);
      end else if (pulses > 1) begin
        error_count++;
        $display("recv_valid pulsed %0d times for a single frame", pulses);
      end else begin
        check_byte(got_data, e.data, "recv_data");
        check_error(got_err, e.exp_err, "recv_error");
      end
      last_rx_byte = e.data;  // The byte is published even when the frame has errors
    end else begin
      if (pulses != 0) begin
        error_count++;
        $display("recv_valid pulsed while the receiver was disabled");
      end
      check_byte(recv_data, last_rx_byte, "recv_data kept while disabled");
    end
  endtask

  task automatic run_tx_entry(input stim_t e, input logic chained, input uart_byte_t next_data);
    logic [frame_bits-1:0] bits;
    int                    waited;
    int                    cyc;
    int                    k;
    logic                  started;
    bits    = {1'b1, even_parity(e.data), e.data, 1'b0};
    waited  = 0;
    started = 1'b1;
    if (chained) begin
      @(negedge clk);
      check_bit(tx, 1'b0, "tx start bit in the cycle after send_done");
    end else begin
      @(posedge clk);
      send_data <= e.data;
      send_en   <= 1'b1;
      @(negedge clk);
      while (tx !== 1'b0 && waited < 4 * clks_per_bit) begin
        @(negedge clk);
        waited++;
      end
      if (tx !== 1'b0) begin
        started = 1'b0;
        error_count++;
        $display("tx never dropped for the start bit of byte 0x%02h", e.data);
      end
    end
    if (started) begin
      cyc = 1;  // Cycle 1 is the first one with tx low
      for (k = 0; k < frame_bits; k++) begin
        while (cyc < k * clks_per_bit + half_bit) begin
          @(negedge clk);
          cyc++;
        end
        check_bit(tx, bits[k], $sformatf("tx bit %0d of byte 0x%02h", k, e.data));
      end
      @(posedge clk);
      if (e.keep_send) begin
        send_data <= next_data;
      end else begin
        send_en <= 1'b0;
      end
      for (cyc = cyc + 1; cyc <= frame_cycles; cyc++) begin
        @(negedge clk);
        check_bit(send_done, logic'(cyc == frame_cycles), $sformatf("send_done in cycle %0d", cyc));
      end
    end
  endtask

  initial begin
    int         errors_before;
    logic       chained;
    uart_byte_t next_data;
    rst_n        = 1'b0;
    rx           = 1'b1;
    recv_en      = 1'b0;
    send_en      = 1'b0;
    send_data    = '0;
    seed         = 32'h09a6_a2cf;
    error_count  = 0;
    pass_count   = 0;
    fail_count   = 0;
    last_rx_byte = '0;  // recv_data comes out of reset as zero

    set_entry(0, kind_tx, 1'b0, 1'b0, 1'b1, 1'b0);
    set_entry(1, kind_rx, 1'b0, 1'b0, 1'b1, 1'b0);
    set_entry(2, kind_rx, 1'b1, 1'b0, 1'b1, 1'b0);
    set_entry(3, kind_rx, 1'b0, 1'b1, 1'b1, 1'b0);
    set_entry(4, kind_rx, 1'b0, 1'b0, 1'b0, 1'b0);  // Receiver disabled
    set_entry(5, kind_rx, 1'b0, 1'b0, 1'b1, 1'b0);
    set_entry(6, kind_tx, 1'b0, 1'b0, 1'b1, 1'b1);
    set_entry(7, kind_tx, 1'b0, 1'b0, 1'b1, 1'b0);
    set_entry(8, kind_rx, 1'b1, 1'b1, 1'b1, 1'b0);
    set_entry(9, kind_tx, 1'b0, 1'b0, 1'b1, 1'b0);

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    errors_before = error_count;
    check_bit(tx, 1'b1, "tx after reset");
    check_bit(recv_valid, 1'b0, "recv_valid after reset");
    check_bit(send_done, 1'b0, "send_done after reset");
    check_error(recv_error, '0, "recv_error after reset");
    check_byte(recv_data, '0, "recv_data after reset");
    if (error_count == errors_before) begin
      pass_count++;
      $display("reset state: passed");
    end else begin
      fail_count++;
      $display("reset state: failed");
    end

    for (int i = 0; i < num_tests; i++) begin
      errors_before = error_count;
      if (stim[i].kind == kind_tx) begin
        chained   = (i > 0) && (stim[i-1].kind == kind_tx) && stim[i-1].keep_send;
        next_data = (i + 1 < num_tests) ? stim[i+1].data : '0;
        run_tx_entry(stim[i], chained, next_data);
      end else begin
        run_rx_entry(stim[i]);
      end
      if (error_count == errors_before) begin
        pass_count++;
      end else begin
        fail_count++;
      end
      $display("test %0d %s byte 0x%02h: %s", i, (stim[i].kind == kind_tx) ? "tx" : "rx",
               stim[i].data, (error_count == errors_before) ? "passed" : "failed");
    end

    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
